/* Bender.yml */
package:
  name: next_space

sources:
  - include_dirs:
      - hw
    files:
      - hw/next_space_pkg.sv
      - hw/gfx_fetch_if.sv
      - hw/table_ram.sv
      - hw/gfx_table_store.sv
      - hw/column_sprite_engine.sv
      - hw/pixel_colour_pipe.sv
      - hw/next_space_video.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/next_space_properties.sv
      - bench/next_space_tb.sv

/* bench/next_space_properties.sv */
// checks are sampled on clk_sys and held off while reset is high
`timescale 1ns/10ps

module next_space_properties (
    input logic clk_sys,
    input logic reset,
    input logic dl_cyc,
    input logic dl_stb,
    input logic dl_ack,
    input logic pix_en,
    input logic rgb_valid,
    input logic fetch_stb,
    input logic fetch_ack
);

    // a fresh download request is answered on the next edge
    assert property (@(posedge clk_sys) disable iff (reset)
        dl_cyc && dl_stb && !dl_ack |=> dl_ack)
        else $error("dl_ack missing one cycle after a download request");

    // fixed colour pipe latency
    assert property (@(posedge clk_sys) disable iff (reset)
        rgb_valid == $past(pix_en, 4))
        else $error("rgb_valid is not pix_en delayed by four cycles");

    // fetch ack one cycle after stb rises, while stb is still up
    assert property (@(posedge clk_sys) disable iff (reset)
        $rose(fetch_stb) |-> !fetch_ack ##1 (fetch_ack && fetch_stb))
        else $error("fetch ack not one cycle after stb or seen while stb is low");

endmodule

bind next_space_video next_space_properties i_next_space_properties (
    .clk_sys, .reset, .dl_cyc, .dl_stb, .dl_ack, .pix_en, .rgb_valid,
    .fetch_stb(fetch_bus.stb), .fetch_ack(fetch_bus.ack)
);

/* bench/next_space_tb.sv */
// needs the sprite, bitmap, tile colour, CLUT and palette tables downloaded before any line is drawn
`timescale 1ns/10ps
`include "next_space_config.svh"

module next_space_tb;

    typedef struct {
        logic [8:0] line;
        int         x0;
        int         cnt;
        bit         blank;
    } line_row_t;

    logic                 clk_sys;
    logic                 reset;
    logic                 dl_cyc;
    logic                 dl_stb;
    logic                 dl_we;
    logic [19:0]          dl_adr;
    logic [7:0]           dl_dat;
    logic                 dl_ack;
    logic                 line_start;
    logic [8:0]           line_num;
    logic                 pix_en;
    logic [7:0]           pix_x;
    next_space_pkg::rgb_t rgb;
    logic                 rgb_valid;
    logic                 line_busy;

    // copies of every downloaded table
    logic [15:0] spr_mem [`NS_SPR_DEPTH];
    logic [15:0] bmp_mem [`NS_BMP_DEPTH];
    logic [7:0]  tcol_mem [`NS_TCOL_DEPTH];
    logic [7:0]  clut_mem [`NS_CLUT_DEPTH];
    logic [31:0] pal_mem [`NS_PAL_DEPTH];
    line_row_t   line_rows [6];
    int unsigned seed;
    logic [31:0] pal_word;
    logic [7:0]  lo;
    logic [7:0]  hi;

    next_space_video i_next_space_video (
        .clk_sys, .reset, .dl_cyc, .dl_stb, .dl_we, .dl_adr, .dl_dat, .dl_ack,
        .line_start, .line_num, .pix_en, .pix_x, .rgb, .rgb_valid, .line_busy
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    // ======================================================================
    // reference model of the renderer and the colour path
    // ======================================================================
    function automatic logic [11:0] buffer_entry(input logic [8:0] line, input int bx);
        logic [11:0] entry;
        logic [15:0] attr;
        logic [15:0] tw;
        logic [15:0] bw;
        logic [7:0]  row;
        logic [2:0]  rs;
        logic [1:0]  g;
        logic [3:0]  pen;
        int          o;
        int          k;
        entry = '0;
        for (int gi = 0; gi < `NS_GROUPS; gi++) begin
            g = (gi == 0) ? 2'd2 : ((gi == 1) ? 2'd3 : 2'd1);
            for (int c = 0; c < `NS_COLS; c++) begin
                attr = spr_mem[{c[4:0], 3'd0, g}];
                row  = ~line[7:0] - (8'd1 - attr[15:8]);
                tw   = spr_mem[{g, c[4:0], row[7:3]}];
                rs   = tw[14] ? ~row[2:0] : row[2:0];
                o    = bx - int'(attr[7:0]);
                if (o >= 0 && o < 8) begin
                    // left half sits at the odd bitmap word
                    bw  = bmp_mem[{tw[8:0], 1'(o < 4), rs}];
                    k   = o % 4;
                    pen = {bw[4 + k], bw[k], bw[12 + k], bw[8 + k]};
                    if (pen != 4'd0) begin
                        entry = {tcol_mem[{tw[13:0], tw[15]}], pen};
                    end
                end
            end
        end
        return entry;
    endfunction

    function automatic logic [23:0] entry_rgb(input logic [11:0] entry);
        logic [31:0] p;
        p = pal_mem[clut_mem[entry[9:0]]];
        return {{2{p[27:24]}}, {2{p[19:16]}}, {2{p[11:8]}}};
    endfunction

    task automatic download_byte(input logic [19:0] adr, input logic [7:0] dat);
        int n;
        n      = 0;
        dl_cyc = 1'b1;
        dl_stb = 1'b1;
        dl_we  = 1'b1;
        dl_adr = adr;
        dl_dat = dat;
        do begin
            @(posedge clk_sys);
            #1;
            n++;
            if (n > 8) stop_run("dl_ack never came for a download write");
        end while (!dl_ack);
        check_value("dl_ack delay", n, 1);
        #1;
        dl_cyc = 1'b0;
        dl_stb = 1'b0;
        dl_we  = 1'b0;
        @(posedge clk_sys);
        #2;
    endtask

    task automatic render_line(input logic [8:0] line);
        int n;
        line_num   = line;
        line_start = 1'b1;
        @(posedge clk_sys);
        #2;
        line_start = 1'b0;
        check_value("line_busy", line_busy, 1);
        n = 0;
        do begin
            @(posedge clk_sys);
            #1;
            n++;
            if (n > 10000) stop_run("line_busy stayed high long after line_start");
        end while (line_busy);
        #1;
    endtask

    // pixels go in back to back, results are matched in order
    task automatic read_line(input line_row_t row);
        logic [23:0] exp_q [$];
        int          t_q [$];
        int          cyc;
        int          issued;
        line_num = row.line + 9'd1;
        cyc      = 0;
        issued   = 0;
        while (issued < row.cnt || t_q.size() > 0) begin
            pix_en = (issued < row.cnt);
            if (pix_en) begin
                pix_x = 8'(row.x0 + issued);
                if (row.blank) begin
                    exp_q.push_back(entry_rgb(12'h000));
                end else begin
                    exp_q.push_back(entry_rgb(buffer_entry(row.line, 255 - int'(pix_x))));
                end
                t_q.push_back(cyc);
                issued++;
            end
            @(posedge clk_sys);
            #1;
            cyc++;
            if (rgb_valid) begin
                if (t_q.size() == 0) stop_run("rgb_valid came with no pixel requested");
                check_value("rgb_valid latency", cyc - t_q.pop_front(), 4);
                check_value("rgb", rgb, exp_q.pop_front());
            end
            if (cyc > row.cnt + 16) stop_run("rgb_valid did not come for every pixel");
            #1;
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed       = $urandom(32'hf9388b76);
        reset      = 1'b1;
        dl_cyc     = 1'b0;
        dl_stb     = 1'b0;
        dl_we      = 1'b0;
        dl_adr     = '0;
        dl_dat     = '0;
        line_start = 1'b0;
        line_num   = '0;
        pix_en     = 1'b0;
        pix_x      = '0;
        // line, first pix_x, pixel count, blank line
        line_rows = '{'{9'd100, 0, 256, 1'b0}, '{9'd101, 0, 256, 1'b0},
                      '{9'd200, 0, 256, 1'b1}, '{9'd201, 0, 256, 1'b1},
                      '{9'd102, 96, 64, 1'b0}, '{9'd99, 0, 256, 1'b0}};
        repeat (2) @(posedge clk_sys);
        #2;
        reset = 1'b0;
        check_value("dl_ack", dl_ack, 0);
        check_value("rgb_valid", rgb_valid, 0);
        check_value("line_busy", line_busy, 0);

        // blank sprite table apart from four columns, all on tile row 19
        for (int w = 0; w < `NS_SPR_DEPTH; w++) begin
            spr_mem[w] = 16'h0000;
        end
        spr_mem[5 * 32 + 2]               = 16'h0128;
        spr_mem[(2 << 10) | (5 << 5) | 19] = 16'h0003;
        spr_mem[9 * 32 + 3]               = 16'h0178;
        spr_mem[(3 << 10) | (9 << 5) | 19] = 16'hc005;
        spr_mem[0 * 32 + 1]               = 16'h012c;
        spr_mem[(1 << 10) | 19]            = 16'h0005;
        spr_mem[31 * 32 + 1]              = 16'h01fc;
        spr_mem[(1 << 10) | (31 << 5) | 19] = 16'h0003;
        for (int w = 0; w < `NS_SPR_DEPTH; w++) begin
            download_byte(`NS_SPR_BASE + 20'(2 * w), spr_mem[w][15:8]);
            download_byte(`NS_SPR_BASE + 20'(2 * w + 1), spr_mem[w][7:0]);
        end
        // tile 0 empty, offsets 0 and 4 always transparent
        for (int w = 0; w < 128; w++) begin
            bmp_mem[w] = (w < 16) ? 16'h0000 : (16'((w * 16'h9e37) ^ 16'h5ac3) & 16'heeee);
            download_byte(`NS_BMP_BASE + 20'(2 * w), bmp_mem[w][15:8]);
            download_byte(`NS_BMP_BASE + 20'(2 * w + 1), bmp_mem[w][7:0]);
        end
        for (int a = 0; a < 16; a++) begin
            tcol_mem[a] = 8'(a * 37 + 11);
            download_byte(`NS_TCOL_BASE + 20'(a), tcol_mem[a]);
        end
        for (int i = 0; i < `NS_CLUT_DEPTH; i++) begin
            lo          = 8'($urandom);
            hi          = 8'($urandom);
            clut_mem[i] = {hi[3:0], lo[3:0]};
            download_byte(`NS_CLUT_BASE + 20'(2 * i), lo);
            download_byte(`NS_CLUT_BASE + 20'(2 * i + 1), hi);
        end
        for (int i = 0; i < `NS_PAL_DEPTH; i++) begin
            pal_word   = $urandom;
            pal_mem[i] = pal_word;
            for (int b = 0; b < 4; b++) begin
                download_byte(`NS_PAL_BASE + 20'(4 * i + b), pal_word[8 * (3 - b) +: 8]);
            end
        end
        // outside every region
        download_byte(20'hf0000, 8'h5a);

        for (int r = 0; r < 6; r++) begin
            render_line(line_rows[r].line);
            read_line(line_rows[r]);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* hw/column_sprite_engine.sv */
// one line is drawn per line_start while idle and pens landing past x 255 are dropped
`timescale 1ns/10ps
`include "next_space_config.svh"

module column_sprite_engine (
    input  logic                       clk_sys,
    input  logic                       reset,
    input  logic                       line_start,
    input  logic [8:0]                 line_num,
    output logic                       line_busy,
    gfx_fetch_if.master                fetch,
    output logic                       buf_we,
    output logic [9:0]                 buf_adr,
    output next_space_pkg::buf_entry_t buf_dat
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_ATTR,
        ST_ROW,
        ST_TILE,
        ST_COLR,
        ST_DRAW,
        ST_NEXT,
        ST_WAIT
    } state_t;

    state_t                       state_q;
    state_t                       ret_q;
    state_t                       req_ret;
    logic [1:0]                   layer_q;
    logic [1:0]                   group_w;
    logic [4:0]                   col_q;
    logic                         half_q;
    logic [7:0]                   line_q;
    logic [8:0]                   x_q;
    logic [7:0]                   row_q;
    logic [7:0]                   row_w;
    logic [2:0]                   row_sel;
    logic [13:0]                  tile_q;
    logic                         flip_q;
    next_space_pkg::tile_colour_t colour_q;
    logic [2:0]                   ofs_q;
    logic [2:0]                   ofs_nxt;
    logic [15:0]                  data_q;
    next_space_pkg::pen_t         pen_w;
    logic                         req_go;
    next_space_pkg::fetch_sel_t   req_sel;
    next_space_pkg::fetch_adr_t   req_adr;

    // groups walked 2, 3, 1
    always_comb begin
        case (layer_q)
            2'd0:    group_w = 2'd2;
            2'd1:    group_w = 2'd3;
            default: group_w = 2'd1;
        endcase
    end

    // column y is 1 minus the attribute high byte
    assign row_w   = line_q - (8'h01 - data_q[15:8]);
    assign row_sel = flip_q ? ~row_q[2:0] : row_q[2:0];
    assign ofs_nxt = ofs_q + 3'd1;
    assign pen_w   = {data_q[4 + ofs_q[1:0]], data_q[ofs_q[1:0]],
                      data_q[12 + ofs_q[1:0]], data_q[8 + ofs_q[1:0]]};

    // ======================================================================
    // fetch requests per state
    // ======================================================================
    always_comb begin
        req_go  = 1'b0;
        req_sel = next_space_pkg::SEL_SPRITE;
        req_adr = '0;
        req_ret = ST_IDLE;
        case (state_q)
            ST_ATTR: begin
                req_go  = 1'b1;
                req_adr = {8'd0, col_q, 3'd0, group_w};
                req_ret = ST_ROW;
            end
            ST_ROW: begin
                req_go  = 1'b1;
                req_adr = {6'd0, group_w, col_q, row_w[7:3]};
                req_ret = ST_TILE;
            end
            ST_TILE: begin
                req_go  = 1'b1;
                req_sel = next_space_pkg::SEL_TCOL;
                req_adr = {3'd0, data_q[13:0], data_q[15]};
                req_ret = ST_COLR;
            end
            ST_COLR, ST_DRAW: begin
                // left half first, right half fetched after the fourth pen
                req_go  = (state_q == ST_COLR) || (ofs_q == 3'd3);
                req_sel = next_space_pkg::SEL_BITMAP;
                req_adr = {tile_q, ~ofs_nxt[2], row_sel};
                req_ret = ST_DRAW;
            end
            default: begin
                req_go = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            line_busy <= 1'b0;
            layer_q   <= 2'd0;
            col_q     <= 5'd0;
            buf_we    <= 1'b0;
            fetch.cyc <= 1'b0;
            fetch.stb <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (line_start) begin
                        state_q   <= ST_CLEAR;
                        line_busy <= 1'b1;
                        layer_q   <= 2'd0;
                        col_q     <= 5'd0;
                    end
                end
                ST_CLEAR: begin
                    buf_we <= 1'b1;
                    if (x_q == 9'(`NS_LINE_PIX + 1)) begin
                        state_q <= ST_ATTR;
                    end
                end
                ST_WAIT: begin
                    if (fetch.ack) begin
                        fetch.cyc <= 1'b0;
                        fetch.stb <= 1'b0;
                        state_q   <= ret_q;
                    end
                end
                ST_DRAW: begin
                    buf_we <= (|pen_w) && !x_q[8];
                    if (ofs_q == 3'd7) begin
                        state_q <= ST_NEXT;
                    end
                end
                ST_NEXT: begin
                    col_q   <= col_q + 5'd1;
                    state_q <= ST_ATTR;
                    if (col_q == 5'(`NS_COLS - 1)) begin
                        layer_q <= layer_q + 2'd1;
                        if (layer_q == 2'(`NS_GROUPS - 1)) begin
                            state_q   <= ST_IDLE;
                            line_busy <= 1'b0;
                        end
                    end
                end
                default: begin
                    state_q <= state_q;
                end
            endcase
            if (req_go) begin
                fetch.cyc <= 1'b1;
                fetch.stb <= 1'b1;
                state_q   <= ST_WAIT;
            end
        end
    end

    // datapath
    always_ff @(posedge clk_sys) begin
        if (state_q == ST_IDLE && line_start) begin
            line_q <= ~line_num[7:0];
            half_q <= line_num[0];
            x_q    <= 9'd0;
        end
        if (state_q == ST_CLEAR || state_q == ST_DRAW) begin
            x_q <= x_q + 9'd1;
        end
        if (state_q == ST_ROW) begin
            x_q    <= {1'b0, data_q[7:0]};
            row_q  <= row_w;
            ofs_q  <= 3'd0;
        end
        if (state_q == ST_TILE) begin
            tile_q <= data_q[13:0];
            flip_q <= data_q[14];
        end
        if (state_q == ST_COLR) begin
            colour_q <= data_q[7:0];
        end
        if (state_q == ST_DRAW) begin
            ofs_q <= ofs_nxt;
        end
        if (state_q == ST_WAIT && fetch.ack) begin
            data_q <= fetch.dat_r;
        end
        if (req_go) begin
            fetch.sel <= req_sel;
            fetch.adr <= req_adr;
            ret_q     <= req_ret;
        end
        buf_adr <= {half_q, x_q};
        if (state_q == ST_CLEAR) begin
            buf_dat <= '0;
        end else begin
            buf_dat <= {4'd0, colour_q, pen_w};
        end
    end

endmodule

/* hw/gfx_fetch_if.sv */
// read-only Wishbone classic without error or retry signalling
`timescale 1ns/10ps

interface gfx_fetch_if;

    logic                       cyc;
    logic                       stb;
    next_space_pkg::fetch_sel_t sel;
    next_space_pkg::fetch_adr_t adr;
    logic [15:0]                dat_r;
    logic                       ack;

    // renderer side
    modport master (
        output cyc,
        output stb,
        output sel,
        output adr,
        input  dat_r,
        input  ack
    );

    // table store side
    modport slave (
        input  cyc,
        input  stb,
        input  sel,
        input  adr,
        output dat_r,
        output ack
    );

endinterface

/* hw/gfx_table_store.sv */
// bytes of one word must arrive in ascending address order and download reads are acked with no data
`timescale 1ns/10ps
`include "next_space_config.svh"

module gfx_table_store (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        dl_cyc,
    input  logic                        dl_stb,
    input  logic                        dl_we,
    input  logic [19:0]                 dl_adr,
    input  logic [7:0]                  dl_dat,
    output logic                        dl_ack,
    gfx_fetch_if.slave                  fetch,
    input  next_space_pkg::clut_index_t clut_adr,
    output logic [7:0]                  clut_dat,
    input  logic [7:0]                  pal_adr,
    output next_space_pkg::pal_word_t   pal_dat
);

    localparam logic [19:0] SPR_END  = 20'(`NS_SPR_BASE + 2 * `NS_SPR_DEPTH);
    localparam logic [19:0] BMP_END  = 20'(`NS_BMP_BASE + 2 * `NS_BMP_DEPTH);
    localparam logic [19:0] TCOL_END = 20'(`NS_TCOL_BASE + `NS_TCOL_DEPTH);
    localparam logic [19:0] CLUT_END = 20'(`NS_CLUT_BASE + 2 * `NS_CLUT_DEPTH);
    localparam logic [19:0] PAL_END  = 20'(`NS_PAL_BASE + 4 * `NS_PAL_DEPTH);

    logic                         dl_wr;
    logic                         in_spr, in_bmp, in_tcol, in_clut, in_pal;
    logic                         spr_we, bmp_we, tcol_we, clut_we, pal_we;
    logic [31:0]                  pack_q;
    logic [14:0]                  adr_q;
    logic                         ack_q;
    next_space_pkg::fetch_sel_t   sel_q;
    logic [15:0]                  spr_rd;
    logic [15:0]                  bmp_rd;
    next_space_pkg::tile_colour_t tcol_rd;

    // a request still high during its own ack is not taken twice
    assign dl_wr   = dl_cyc && dl_stb && dl_we && !dl_ack;
    assign in_spr  = (dl_adr >= `NS_SPR_BASE) && (dl_adr < SPR_END);
    assign in_bmp  = (dl_adr >= `NS_BMP_BASE) && (dl_adr < BMP_END);
    assign in_tcol = (dl_adr >= `NS_TCOL_BASE) && (dl_adr < TCOL_END);
    assign in_clut = (dl_adr >= `NS_CLUT_BASE) && (dl_adr < CLUT_END);
    assign in_pal  = (dl_adr >= `NS_PAL_BASE) && (dl_adr < PAL_END);

    // word writes fire one cycle after the last byte, from the packed bytes
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dl_ack  <= 1'b0;
            spr_we  <= 1'b0;
            bmp_we  <= 1'b0;
            tcol_we <= 1'b0;
            clut_we <= 1'b0;
            pal_we  <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            dl_ack  <= dl_cyc && dl_stb && !dl_ack;
            spr_we  <= dl_wr && in_spr && dl_adr[0];
            bmp_we  <= dl_wr && in_bmp && dl_adr[0];
            tcol_we <= dl_wr && in_tcol;
            clut_we <= dl_wr && in_clut && dl_adr[0];
            pal_we  <= dl_wr && in_pal && (&dl_adr[1:0]);
            ack_q   <= fetch.cyc && fetch.stb;
        end
    end

    // big-endian byte shifter shared by all regions
    always_ff @(posedge clk_sys) begin
        if (dl_wr) begin
            pack_q <= {pack_q[23:0], dl_dat};
            adr_q  <= dl_adr[14:0];
        end
        sel_q <= fetch.sel;
    end

    // ======================================================================
    // tables
    // ======================================================================
    table_ram #(.word_t(logic [15:0]), .DEPTH(`NS_SPR_DEPTH)) i_spr_ram (
        .clk_sys, .wr_en(spr_we), .wr_adr(adr_q[12:1]), .wr_dat(pack_q[15:0]),
        .rd_adr(fetch.adr[11:0]), .rd_dat(spr_rd)
    );
    table_ram #(.word_t(logic [15:0]), .DEPTH(`NS_BMP_DEPTH)) i_bmp_ram (
        .clk_sys, .wr_en(bmp_we), .wr_adr(adr_q[13:1]), .wr_dat(pack_q[15:0]),
        .rd_adr(fetch.adr[12:0]), .rd_dat(bmp_rd)
    );
    table_ram #(.word_t(next_space_pkg::tile_colour_t), .DEPTH(`NS_TCOL_DEPTH)) i_tcol_ram (
        .clk_sys, .wr_en(tcol_we), .wr_adr(adr_q[14:0]), .wr_dat(pack_q[7:0]),
        .rd_adr(fetch.adr[14:0]), .rd_dat(tcol_rd)
    );
    // even byte nibble low, odd byte nibble high
    table_ram #(.word_t(logic [7:0]), .DEPTH(`NS_CLUT_DEPTH)) i_clut_ram (
        .clk_sys, .wr_en(clut_we), .wr_adr(adr_q[10:1]), .wr_dat({pack_q[3:0], pack_q[11:8]}),
        .rd_adr(clut_adr[9:0]), .rd_dat(clut_dat)
    );
    table_ram #(.word_t(next_space_pkg::pal_word_t), .DEPTH(`NS_PAL_DEPTH)) i_pal_ram (
        .clk_sys, .wr_en(pal_we), .wr_adr(adr_q[9:2]), .wr_dat(pack_q),
        .rd_adr(pal_adr), .rd_dat(pal_dat)
    );

    always_comb begin
        case (sel_q)
            next_space_pkg::SEL_SPRITE: fetch.dat_r = spr_rd;
            next_space_pkg::SEL_TCOL:   fetch.dat_r = {8'h00, tcol_rd};
            default:                    fetch.dat_r = bmp_rd;
        endcase
    end

    // held while stb stays up, gone as soon as it drops
    assign fetch.ack = ack_q && fetch.stb;

endmodule

/* hw/next_space_config.svh */
// download regions must start on a multiple of their own size and the bitmap table holds tiles 0 to 511 only
`ifndef NEXT_SPACE_CONFIG_SVH
`define NEXT_SPACE_CONFIG_SVH

// ======================================================================
// line geometry
// ======================================================================
`define NS_COLS       32
`define NS_GROUPS     3
`define NS_LINE_PIX   256

// ======================================================================
// table depths in words
// ======================================================================
`define NS_SPR_DEPTH  4096
`define NS_BMP_DEPTH  8192
`define NS_TCOL_DEPTH 32768
`define NS_CLUT_DEPTH 1024
`define NS_PAL_DEPTH  256

// ======================================================================
// download regions, byte addresses
// ======================================================================
`define NS_SPR_BASE   20'h00000
`define NS_BMP_BASE   20'h10000
`define NS_TCOL_BASE  20'h20000
`define NS_CLUT_BASE  20'h28000
`define NS_PAL_BASE   20'h28800

`endif

/* hw/next_space_pkg.sv */
// types only and no parameters, so depths and address maps stay in the config header
package next_space_pkg;

    // pen 0 is transparent
    typedef logic [3:0] pen_t;

    // colour bank from the tile colour table
    typedef logic [7:0] tile_colour_t;

    // one line buffer word
    typedef struct packed {
        logic [3:0]   pad;
        tile_colour_t colour;
        pen_t         pen;
    } buf_entry_t;

    // colour and pen, only the low 10 bits reach the CLUT
    typedef logic [11:0] clut_index_t;

    // channels sit at 27:24, 19:16 and 11:8
    typedef logic [31:0] pal_word_t;

    // table targets of a renderer fetch
    typedef enum logic [1:0] {
        SEL_SPRITE,
        SEL_TCOL,
        SEL_BITMAP
    } fetch_sel_t;

    typedef logic [17:0] fetch_adr_t;

    typedef logic [23:0] rgb_t;

endpackage

/* hw/next_space_video.sv */
// line timing comes in on ports and everything runs on clk_sys with no clock enables
`timescale 1ns/10ps
`include "next_space_config.svh"

module next_space_video (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 dl_cyc,
    input  logic                 dl_stb,
    input  logic                 dl_we,
    input  logic [19:0]          dl_adr,
    input  logic [7:0]           dl_dat,
    output logic                 dl_ack,
    input  logic                 line_start,
    input  logic [8:0]           line_num,
    input  logic                 pix_en,
    input  logic [7:0]           pix_x,
    output next_space_pkg::rgb_t rgb,
    output logic                 rgb_valid,
    output logic                 line_busy
);

    logic                        buf_we;
    logic [9:0]                  wr_buf_adr;
    logic [9:0]                  rd_buf_adr;
    next_space_pkg::buf_entry_t  wr_buf_dat;
    next_space_pkg::buf_entry_t  rd_buf_dat;
    next_space_pkg::clut_index_t clut_adr;
    logic [7:0]                  clut_dat;
    logic [7:0]                  pal_adr;
    next_space_pkg::pal_word_t   pal_dat;

    gfx_fetch_if fetch_bus ();

    gfx_table_store i_gfx_table_store (
        .clk_sys, .reset, .dl_cyc, .dl_stb, .dl_we, .dl_adr, .dl_dat, .dl_ack,
        .fetch(fetch_bus), .clut_adr, .clut_dat, .pal_adr, .pal_dat
    );

    column_sprite_engine i_column_sprite_engine (
        .clk_sys, .reset, .line_start, .line_num, .line_busy,
        .fetch(fetch_bus), .buf_we, .buf_adr(wr_buf_adr), .buf_dat(wr_buf_dat)
    );

    // two halves of 256, bit 8 of the engine address is the off-screen margin
    table_ram #(.word_t(next_space_pkg::buf_entry_t), .DEPTH(2 * `NS_LINE_PIX)) i_line_buf (
        .clk_sys, .wr_en(buf_we), .wr_adr({wr_buf_adr[9], wr_buf_adr[7:0]}), .wr_dat(wr_buf_dat),
        .rd_adr({rd_buf_adr[9], rd_buf_adr[7:0]}), .rd_dat(rd_buf_dat)
    );

    pixel_colour_pipe i_pixel_colour_pipe (
        .clk_sys, .reset, .pix_en, .pix_x, .line_num,
        .buf_adr(rd_buf_adr), .buf_dat(rd_buf_dat), .clut_adr, .clut_dat,
        .pal_adr, .pal_dat, .rgb, .rgb_valid
    );

endmodule

/* hw/pixel_colour_pipe.sv */
// fixed four-cycle latency at one pixel per cycle reading the half that is not being drawn
`timescale 1ns/10ps

module pixel_colour_pipe (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        pix_en,
    input  logic [7:0]                  pix_x,
    input  logic [8:0]                  line_num,
    output logic [9:0]                  buf_adr,
    input  next_space_pkg::buf_entry_t  buf_dat,
    output next_space_pkg::clut_index_t clut_adr,
    input  logic [7:0]                  clut_dat,
    output logic [7:0]                  pal_adr,
    input  next_space_pkg::pal_word_t   pal_dat,
    output next_space_pkg::rgb_t        rgb,
    output logic                        rgb_valid
);

    logic [2:0] valid_q;

    // ======================================================================
    // address chain through the registered tables
    // ======================================================================

    // screen is mirrored so x counts down through the buffer
    assign buf_adr  = {~line_num[0], 1'b0, ~pix_x};
    assign clut_adr = {buf_dat.colour, buf_dat.pen};
    assign pal_adr  = clut_dat;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            valid_q   <= 3'd0;
            rgb_valid <= 1'b0;
        end else begin
            valid_q   <= {valid_q[1:0], pix_en};
            rgb_valid <= valid_q[2];
        end
    end

    // 4-bit channels doubled up to 8 bits
    always_ff @(posedge clk_sys) begin
        if (valid_q[2]) begin
            rgb <= {{2{pal_dat[27:24]}}, {2{pal_dat[19:16]}}, {2{pal_dat[11:8]}}};
        end
    end

endmodule

/* hw/table_ram.sv */
// read data is registered and a read of the word being written returns the old value
`timescale 1ns/10ps

module table_ram #(
    parameter type word_t = logic [15:0],
    parameter int  DEPTH  = 1024
) (
    input  logic                     clk_sys,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_adr,
    input  word_t                    wr_dat,
    input  logic [$clog2(DEPTH)-1:0] rd_adr,
    output word_t                    rd_dat
);

    word_t mem [DEPTH];

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_adr] <= wr_dat;
        end
        rd_dat <= mem[rd_adr];
    end

endmodule

/* next_space.f */
+incdir+hw
hw/next_space_pkg.sv
hw/gfx_fetch_if.sv
hw/table_ram.sv
hw/gfx_table_store.sv
hw/column_sprite_engine.sv
hw/pixel_colour_pipe.sv
hw/next_space_video.sv
bench/next_space_properties.sv
bench/next_space_tb.sv
